// File: src/cdc_fifo_macros.svh
/* CDC FIFO sizing: word widths, depths on both sides, synchronizer
   depth and the consumer credit limit */

`ifndef CDC_FIFO_MACROS_SVH
`define CDC_FIFO_MACROS_SVH

// Write side is the wide side
`define CDC_FIFO_WR_WIDTH 64
`define CDC_FIFO_RD_WIDTH 32

// Same storage counted in write words and in read words
`define CDC_FIFO_WR_DEPTH 32
`define CDC_FIFO_RD_DEPTH 64

`define CDC_FIFO_SYNC_STAGES 2 // Flops per pointer crossing

// Upper bound on credits the consumer keeps outstanding
`define CDC_FIFO_CREDIT_MAX 4

`endif

// File: src/fifo_ptr_pkg.sv
/* Pointer and count types for the write and read sides of the FIFO */

`default_nettype none

`include "cdc_fifo_macros.svh"

package fifo_ptr_pkg;

    // Binary pointers carry one wrap bit above the address
    typedef logic [$clog2(`CDC_FIFO_WR_DEPTH):0] wr_ptr_t;
    typedef logic [$clog2(`CDC_FIFO_RD_DEPTH):0] rd_ptr_t;

    // Free space in write words, 0 to WR_DEPTH
    typedef logic [$clog2(`CDC_FIFO_WR_DEPTH):0] wr_cnt_t;

    // Available data in read words, 0 to RD_DEPTH
    typedef logic [$clog2(`CDC_FIFO_RD_DEPTH):0] rd_cnt_t;

endpackage

`default_nettype wire

// File: src/fifo_link_pkg.sv
/* Data word types for both FIFO ports and the drain credit counter */

`default_nettype none

`include "cdc_fifo_macros.svh"

package fifo_link_pkg;

    typedef logic [`CDC_FIFO_WR_WIDTH-1:0] wr_word_t; // Producer side
    typedef logic [`CDC_FIFO_RD_WIDTH-1:0] rd_word_t; // Consumer side

    // Holds 0 to CREDIT_MAX inclusive
    typedef logic [$clog2(`CDC_FIFO_CREDIT_MAX+1)-1:0] credit_t;

endpackage

`default_nettype wire

// File: src/fifo_rd_if.sv
/* Read port of the FIFO core as seen by the credit drain */

`timescale 1ns/1ps
`default_nettype none

interface fifo_rd_if;

    logic                    rd_en;    // Pop on the edge where this is high
    fifo_link_pkg::rd_word_t rd_data;  // Valid on the edge after a pop
    logic                    rd_empty;
    fifo_ptr_pkg::rd_cnt_t   rd_avail; // Read words in the FIFO

    // Core side
    modport fifo (
        input  rd_en,
        output rd_data,
        output rd_empty,
        output rd_avail
    );

    // Only pops while rd_empty is low
    modport drain (
        output rd_en,
        input  rd_data,
        input  rd_empty,
        input  rd_avail
    );

endinterface

`default_nettype wire

// File: src/ptr_gray_sync.sv
/* Pointer crossing: registered Gray encode in the source clock, sync chain
   and binary decode in the destination clock */

`timescale 1ns/1ps
`default_nettype none

`include "cdc_fifo_macros.svh"

module ptr_gray_sync #(
    parameter int PTR_WIDTH = 6
) (
    input  wire                  src_clk_i,
    input  wire                  src_rst_n_i,
    input  wire                  dst_clk_i,
    input  wire                  dst_rst_n_i,
    input  wire  [PTR_WIDTH-1:0] bin_i,
    output logic [PTR_WIDTH-1:0] bin_o,
    output logic [PTR_WIDTH-1:0] gray_o
);

    localparam int STAGES = `CDC_FIFO_SYNC_STAGES;

    logic [PTR_WIDTH-1:0]             gray_src_q; // Launch flop, one bit moves per step
    logic [STAGES-1:0][PTR_WIDTH-1:0] sync_q;

    always_ff @(posedge src_clk_i or negedge src_rst_n_i) begin
        if (!src_rst_n_i) begin
            gray_src_q <= '0;
        end else begin
            gray_src_q <= bin_i ^ (bin_i >> 1);
        end
    end

    // Stage 0 may go metastable, later stages settle it
    always_ff @(posedge dst_clk_i or negedge dst_rst_n_i) begin
        if (!dst_rst_n_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[STAGES-2:0], gray_src_q};
        end
    end

    assign gray_o = sync_q[STAGES-1];

    // Each binary bit is the XOR of all Gray bits at and above it
    always_comb begin
        for (int i = 0; i < PTR_WIDTH; i++) begin
            bin_o[i] = ^(gray_o >> i);
        end
    end

endmodule

`default_nettype wire

// File: src/ram_tp.sv
/* Two-port RAM, written in wide words and read back in narrow words
   with a registered read */

`timescale 1ns/1ps
`default_nettype none

`include "cdc_fifo_macros.svh"

module ram_tp (
    input  wire                                    wr_clk_i,
    input  wire                                    wr_en_i,
    input  wire  [$clog2(`CDC_FIFO_WR_DEPTH)-1:0]  wr_addr_i,
    input  wire  fifo_link_pkg::wr_word_t          wr_data_i,
    input  wire                                    rd_clk_i,
    input  wire                                    rd_en_i,
    input  wire  [$clog2(`CDC_FIFO_RD_DEPTH)-1:0]  rd_addr_i,
    output fifo_link_pkg::rd_word_t                rd_data_o
);

    localparam int RATIO = `CDC_FIFO_WR_WIDTH / `CDC_FIFO_RD_WIDTH; // Narrow words per row
    localparam int SEL_W = $clog2(RATIO);
    localparam int RD_AW = $clog2(`CDC_FIFO_RD_DEPTH);

    // Each row is one wide word, element 0 is the low half
    fifo_link_pkg::rd_word_t [RATIO-1:0] mem_q [`CDC_FIFO_WR_DEPTH];

    logic [RD_AW-SEL_W-1:0] rd_row; // Wide word holding the read
    logic [SEL_W-1:0]       rd_sel; // Which narrow slice of it

    assign rd_row = rd_addr_i[RD_AW-1:SEL_W];
    assign rd_sel = rd_addr_i[SEL_W-1:0];

    always_ff @(posedge wr_clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
    end

    // Output holds its value between pops
    always_ff @(posedge rd_clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_row][rd_sel];
        end
    end

endmodule

`default_nettype wire

// File: src/fifo.sv
/* Dual-clock FIFO core, 64-bit writes in and 32-bit reads out, with
   Gray pointer crossing, full/empty flags and free/available counts */

`timescale 1ns/1ps
`default_nettype none

`include "cdc_fifo_macros.svh"

module fifo (
    input  wire                       wr_clk_i,
    input  wire                       wr_rst_n_i,
    input  wire                       wr_en_i,
    input  wire fifo_link_pkg::wr_word_t wr_data_i,
    output logic                      wr_full_o,
    output fifo_ptr_pkg::wr_cnt_t     wr_free_o,
    input  wire                       rd_clk_i,
    input  wire                       rd_rst_n_i,
    fifo_rd_if.fifo                   rd
);

    localparam int WR_AW = $clog2(`CDC_FIFO_WR_DEPTH);
    localparam int RD_AW = $clog2(`CDC_FIFO_RD_DEPTH);

    // Write domain
    fifo_ptr_pkg::wr_ptr_t wr_ptr_q;
    fifo_ptr_pkg::rd_ptr_t wr_ext_w;    // Write pointer in read-word units
    fifo_ptr_pkg::rd_ptr_t rd_bin_ws;   // Read pointer after crossing
    fifo_ptr_pkg::rd_ptr_t used_w;
    fifo_ptr_pkg::rd_ptr_t free_half_w;
    logic                  wr_push;

    // Read domain
    fifo_ptr_pkg::rd_ptr_t rd_ptr_q;
    fifo_ptr_pkg::rd_ptr_t rd_gray_r;
    fifo_ptr_pkg::wr_ptr_t wr_gray_rs;  // Write pointer after crossing, Gray
    fifo_ptr_pkg::wr_ptr_t wr_bin_rs;   // Same, decoded
    fifo_ptr_pkg::rd_ptr_t wr_ext_r;
    fifo_ptr_pkg::rd_ptr_t wr_gray_ext_r;

    assign wr_push = wr_en_i & ~wr_full_o; // Writes while full are dropped

    // One wide word is two narrow words, so extend by one zero bit
    assign wr_ext_w = {wr_ptr_q, 1'b0};
    assign wr_ext_r = {wr_bin_rs, 1'b0};

    // Gray of {b, 0} is {gray(b), b[0]}
    assign wr_gray_ext_r = {wr_gray_rs, wr_bin_rs[0]};
    assign rd_gray_r     = rd_ptr_q ^ (rd_ptr_q >> 1);

    // A half-read word still holds its slot, so the sub-word bit is ignored
    assign wr_full_o = (rd_bin_ws[RD_AW:1] == {~wr_ptr_q[WR_AW], wr_ptr_q[WR_AW-1:0]});

    // Free space rounds down to whole write words
    assign used_w      = wr_ext_w - rd_bin_ws;
    assign free_half_w = fifo_ptr_pkg::rd_ptr_t'(`CDC_FIFO_RD_DEPTH) - used_w;
    assign wr_free_o   = free_half_w[RD_AW:1];

    assign rd.rd_empty = (rd_gray_r == wr_gray_ext_r);
    assign rd.rd_avail = wr_ext_r - rd_ptr_q;

    always_ff @(posedge wr_clk_i or negedge wr_rst_n_i) begin
        if (!wr_rst_n_i) begin
            wr_ptr_q <= '0;
        end else if (wr_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    // Drain only pops while not empty
    always_ff @(posedge rd_clk_i or negedge rd_rst_n_i) begin
        if (!rd_rst_n_i) begin
            rd_ptr_q <= '0;
        end else if (rd.rd_en) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    ptr_gray_sync #(
        .PTR_WIDTH(WR_AW + 1)
    ) u_sync_w2r (
        .src_clk_i  (wr_clk_i),
        .src_rst_n_i(wr_rst_n_i),
        .dst_clk_i  (rd_clk_i),
        .dst_rst_n_i(rd_rst_n_i),
        .bin_i      (wr_ptr_q),
        .bin_o      (wr_bin_rs),
        .gray_o     (wr_gray_rs)
    );

    // Write side only needs the decoded read pointer
    ptr_gray_sync #(
        .PTR_WIDTH(RD_AW + 1)
    ) u_sync_r2w (
        .src_clk_i  (rd_clk_i),
        .src_rst_n_i(rd_rst_n_i),
        .dst_clk_i  (wr_clk_i),
        .dst_rst_n_i(wr_rst_n_i),
        .bin_i      (rd_ptr_q),
        .bin_o      (rd_bin_ws),
        .gray_o     ()
    );

    ram_tp u_ram (
        .wr_clk_i (wr_clk_i),
        .wr_en_i  (wr_push),
        .wr_addr_i(wr_ptr_q[WR_AW-1:0]),
        .wr_data_i(wr_data_i),
        .rd_clk_i (rd_clk_i),
        .rd_en_i  (rd.rd_en),
        .rd_addr_i(rd_ptr_q[RD_AW-1:0]),
        .rd_data_o(rd.rd_data)
    );

endmodule

`default_nettype wire

// File: src/credit_drain.sv
/* Read-side drain: counts consumer credits and pops the FIFO only while
   a credit is held, flagging each delivered word with a valid pulse */

`timescale 1ns/1ps
`default_nettype none

module credit_drain (
    input  wire                     rd_clk_i,
    input  wire                     rd_rst_n_i,
    fifo_rd_if.drain                rd,
    input  wire                     rd_credit_i,
    output logic                    rd_valid_o,
    output fifo_link_pkg::rd_word_t rd_data_o
);

    fifo_link_pkg::credit_t credit_q; // Credits granted and not yet used
    logic                   pop;
    logic                   valid_q;

    // Each pop spends one credit
    assign pop   = (credit_q != '0) && !rd.rd_empty;
    assign rd.rd_en = pop;

    // Grant and pop may land in the same cycle
    always_ff @(posedge rd_clk_i or negedge rd_rst_n_i) begin
        if (!rd_rst_n_i) begin
            credit_q <= '0;
        end else begin
            credit_q <= credit_q + fifo_link_pkg::credit_t'(rd_credit_i)
                                 - fifo_link_pkg::credit_t'(pop);
        end
    end

    // RAM output is registered on the pop edge, valid follows it
    always_ff @(posedge rd_clk_i or negedge rd_rst_n_i) begin
        if (!rd_rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pop;
        end
    end

    assign rd_valid_o = valid_q;
    assign rd_data_o  = rd.rd_data; // Straight from the RAM read register

endmodule

`default_nettype wire

// File: src/cdc_fifo_top.sv
/* Dual-clock 64-to-32 FIFO with credit-based read side, top level */

`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_top (
    // Write domain
    input  wire                          wr_clk_i,
    input  wire                          wr_rst_n_i,
    input  wire                          wr_en_i,
    input  wire fifo_link_pkg::wr_word_t wr_data_i,
    output logic                         wr_full_o,
    output fifo_ptr_pkg::wr_cnt_t        wr_free_o,

    // Read domain
    input  wire                          rd_clk_i,
    input  wire                          rd_rst_n_i,
    input  wire                          rd_credit_i,
    output logic                         rd_valid_o,
    output fifo_link_pkg::rd_word_t      rd_data_o
);

    fifo_rd_if u_rd_if ();

    fifo u_fifo (
        .wr_clk_i  (wr_clk_i),
        .wr_rst_n_i(wr_rst_n_i),
        .wr_en_i   (wr_en_i),
        .wr_data_i (wr_data_i),
        .wr_full_o (wr_full_o),
        .wr_free_o (wr_free_o),
        .rd_clk_i  (rd_clk_i),
        .rd_rst_n_i(rd_rst_n_i),
        .rd        (u_rd_if.fifo)
    );

    // Pops on behalf of the consumer
    credit_drain u_drain (
        .rd_clk_i   (rd_clk_i),
        .rd_rst_n_i (rd_rst_n_i),
        .rd         (u_rd_if.drain),
        .rd_credit_i(rd_credit_i),
        .rd_valid_o (rd_valid_o),
        .rd_data_o  (rd_data_o)
    );

endmodule

`default_nettype wire

// File: tb/cdc_fifo_properties.sv
/* Concurrent checks on the CDC FIFO top level: credit rule, free count
   range and output values while reset is held */

`timescale 1ns/1ps
`default_nettype none

`include "cdc_fifo_macros.svh"

module cdc_fifo_properties (
    input wire                        rd_clk_i,
    input wire                        rd_rst_n_i,
    input wire                        rd_credit_i,
    input wire                        rd_valid_o,
    input wire                        wr_clk_i,
    input wire                        wr_rst_n_i,
    input wire                        wr_full_o,
    input wire fifo_ptr_pkg::wr_cnt_t wr_free_o
);

    localparam fifo_ptr_pkg::wr_cnt_t FREE_MAX = fifo_ptr_pkg::wr_cnt_t'(`CDC_FIFO_WR_DEPTH);

    int outstanding_q;      // Credits granted minus words delivered
    int valid_fail_cnt = 0;
    int free_fail_cnt = 0;
    int wr_rst_fail_cnt = 0;
    int rd_rst_fail_cnt = 0;

    always_ff @(posedge rd_clk_i or negedge rd_rst_n_i) begin
        if (!rd_rst_n_i) begin
            outstanding_q <= 0;
        end else begin
            outstanding_q <= outstanding_q + int'(rd_credit_i) - int'(rd_valid_o);
        end
    end

    // A delivered word must be covered by an earlier grant
    valid_needs_credit: assert property (@(posedge rd_clk_i) disable iff (!rd_rst_n_i)
        rd_valid_o |-> outstanding_q > 0)
    else begin
        valid_fail_cnt++;
        $error("valid without an outstanding credit");
    end

    free_in_range: assert property (@(posedge wr_clk_i) disable iff (!wr_rst_n_i)
        wr_free_o <= FREE_MAX)
    else begin
        free_fail_cnt++;
        $error("free count above FIFO depth");
    end

    wr_reset_values: assert property (@(posedge wr_clk_i)
        !wr_rst_n_i |-> !wr_full_o && wr_free_o == FREE_MAX)
    else begin
        wr_rst_fail_cnt++;
        $error("write side flags wrong during reset");
    end

    rd_reset_values: assert property (@(posedge rd_clk_i) !rd_rst_n_i |-> !rd_valid_o)
    else begin
        rd_rst_fail_cnt++;
        $error("valid high during reset");
    end

endmodule

bind cdc_fifo_top cdc_fifo_properties u_props (.*);

`default_nettype wire

// File: tb/cdc_fifo_tb.sv
/* Testbench for the CDC FIFO with sparse streaming, a fill to full with
   dropped writes and a drain to empty, all checked against a queue model */

`timescale 1ns/1ps
`default_nettype none

`include "cdc_fifo_macros.svh"

module cdc_fifo_tb;

    localparam int RD_PERIOD   = 40;
    localparam int N_STREAM    = 40; // Sparse writes while credits flow
    localparam int N_FILL      = 40; // Back-to-back writes, no credits
    localparam int WATCHDOG_NS = (N_STREAM + N_FILL) * 4 * RD_PERIOD + 2000;

    logic                    wr_clk;
    logic                    wr_rst_n;
    logic                    wr_en;
    fifo_link_pkg::wr_word_t wr_data;
    logic                    wr_full;
    fifo_ptr_pkg::wr_cnt_t   wr_free;
    logic                    rd_clk;
    logic                    rd_rst_n;
    logic                    rd_credit;
    logic                    rd_valid;
    fifo_link_pkg::rd_word_t rd_data;

    fifo_link_pkg::rd_word_t model_q[$]; // Expected read words, oldest first
    int          errors;
    int          assert_errs;
    int          accepted_total;
    int          fill_acc;
    int          credits_sent;
    int          words_seen;
    bit          credit_on;
    bit          fill_phase;
    string       test_name;
    int unsigned seed_ret;

    cdc_fifo_top dut0 (
        .wr_clk_i   (wr_clk),
        .wr_rst_n_i (wr_rst_n),
        .wr_en_i    (wr_en),
        .wr_data_i  (wr_data),
        .wr_full_o  (wr_full),
        .wr_free_o  (wr_free),
        .rd_clk_i   (rd_clk),
        .rd_rst_n_i (rd_rst_n),
        .rd_credit_i(rd_credit),
        .rd_valid_o (rd_valid),
        .rd_data_o  (rd_data)
    );

    always #(RD_PERIOD / 2) rd_clk = ~rd_clk;
    always #14 wr_clk = ~wr_clk; // 28 ns write period

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
            errors = errors + 1;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("error in %s: %s", test_name, msg);
        errors = errors + 1;
    endtask

    // Dense mode writes every cycle and sparse mode about every other cycle
    task automatic write_words(input int n, input bit dense);
        int issued;
        issued = 0;
        while (issued < n) begin
            @(posedge wr_clk);
            #2;
            wr_en = dense || ($urandom_range(1, 0) == 1);
            if (wr_en) begin
                wr_data = {$urandom(), $urandom()};
                issued  = issued + 1;
            end
        end
        @(posedge wr_clk);
        #2;
        wr_en = 1'b0;
    endtask

    // Write side is stable at the falling edge; accepted writes feed the model
    always @(negedge wr_clk) begin
        if (wr_rst_n) begin
            assert (wr_free <= fifo_ptr_pkg::wr_cnt_t'(`CDC_FIFO_WR_DEPTH))
                else report_failure("free count above FIFO depth");
            if (fill_phase && wr_full) begin
                check_equal("fill_threshold", 64'(`CDC_FIFO_WR_DEPTH), 64'(fill_acc));
            end
            if (wr_en && !wr_full) begin
                model_q.push_back(wr_data[31:0]); // Low half leaves first
                model_q.push_back(wr_data[63:32]);
                accepted_total = accepted_total + 1;
                if (fill_phase) fill_acc = fill_acc + 1;
            end
        end
    end

    always @(negedge rd_clk) begin
        fifo_link_pkg::rd_word_t exp_word;
        if (rd_rst_n && rd_valid) begin
            words_seen = words_seen + 1;
            assert (words_seen <= credits_sent) else report_failure("word without a credit");
            assert (model_q.size() > 0) else report_failure("word with the model empty");
            if (model_q.size() > 0) begin
                exp_word = model_q.pop_front();
                check_equal(test_name, 64'(exp_word), 64'(rd_data));
            end
        end
    end

    // Consumer grants only what the model still owes and never above the limit
    initial begin
        forever begin
            @(posedge rd_clk);
            #2;
            rd_credit = 1'b0;
            if (credit_on && credits_sent < 2 * accepted_total
                    && credits_sent - words_seen < `CDC_FIFO_CREDIT_MAX
                    && $urandom_range(3, 0) != 0) begin
                rd_credit    = 1'b1;
                credits_sent = credits_sent + 1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run still busy after %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed_ret = $urandom(32'h78a9_b094);
        {wr_clk, rd_clk, wr_en, rd_credit, credit_on, fill_phase} = '0;
        wr_data        = '0;
        {errors, accepted_total, fill_acc, credits_sent, words_seen} = '0;
        test_name      = "reset";
        wr_rst_n       = 1'b1;
        rd_rst_n       = 1'b1;
        #1;
        wr_rst_n = 1'b0; // Falling edge starts the async reset
        rd_rst_n = 1'b0;
        repeat (10) @(posedge rd_clk);
        #2;
        wr_rst_n = 1'b1;
        rd_rst_n = 1'b1;
        @(negedge rd_clk);
        check_equal("reset_valid", 64'd0, 64'(rd_valid));
        check_equal("reset_full", 64'd0, 64'(wr_full));
        check_equal("reset_free", 64'(`CDC_FIFO_WR_DEPTH), 64'(wr_free));

        test_name = "stream";
        credit_on = 1'b1;
        write_words(N_STREAM, 1'b0);
        wait (words_seen == 2 * accepted_total);
        assert (model_q.size() == 0) else report_failure("stream words left undelivered");

        credit_on = 1'b0;
        repeat (8) @(negedge wr_clk); // Read pointer crossing settles
        check_equal("idle_free", 64'(`CDC_FIFO_WR_DEPTH), 64'(wr_free));

        test_name  = "fill";
        fill_phase = 1'b1;
        write_words(N_FILL, 1'b1);
        check_equal("fill_count", 64'(`CDC_FIFO_WR_DEPTH), 64'(fill_acc));
        assert (wr_full) else report_failure("FIFO not full after back-to-back writes");
        fill_phase = 1'b0;
        @(negedge rd_clk); // Full FIFO holds every read word
        check_equal("fill_avail", 64'(`CDC_FIFO_RD_DEPTH), 64'(dut0.u_rd_if.rd_avail));

        test_name = "drain";
        credit_on = 1'b1;
        wait (words_seen == 2 * accepted_total);
        assert (model_q.size() == 0) else report_failure("queued words never arrived");
        repeat (8) @(negedge wr_clk);
        check_equal("drain_free", 64'(`CDC_FIFO_WR_DEPTH), 64'(wr_free));
        check_equal("drain_full", 64'd0, 64'(wr_full));

        assert_errs = dut0.u_props.valid_fail_cnt + dut0.u_props.free_fail_cnt
                    + dut0.u_props.wr_rst_fail_cnt + dut0.u_props.rd_rst_fail_cnt;
        $display("checks done: %0d testbench errors, %0d assertion errors",
                 errors, assert_errs);
        if (errors == 0 && assert_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+src
src/fifo_ptr_pkg.sv
src/fifo_link_pkg.sv
src/fifo_rd_if.sv
src/ptr_gray_sync.sv
src/ram_tp.sv
src/fifo.sv
src/credit_drain.sv
src/cdc_fifo_top.sv
tb/cdc_fifo_properties.sv
tb/cdc_fifo_tb.sv

// File: Makefile
# Verilator simulation of the CDC FIFO testbench

VERILATOR ?= verilator
TOP       ?= cdc_fifo_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
